//--- Makefile
# Verilator build and run for the serial calculator testbench
TOP = tb_uart_calc

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/calc_pkg.sv
// calc_pkg
// shared constants and types for the serial calculator
// bit timing, ASCII codes, received character view, expression word

package calc_pkg;

    //----------------------------------------------------------------------
    // bit timing
    //----------------------------------------------------------------------
    localparam int CLKS_PER_BIT = 16;                     // CLKOP cycles per serial bit
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);   // counts 0 .. CLKS_PER_BIT-1

    //----------------------------------------------------------------------
    // character codes
    //----------------------------------------------------------------------
    localparam logic [7:0] CHAR_ESC   = 8'h1B;  // abort partial expression
    localparam logic [7:0] CHAR_PLUS  = 8'h2B;  // '+'
    localparam logic [7:0] CHAR_MINUS = 8'h2D;  // '-', also the result sign
    localparam logic [7:0] CHAR_EQUAL = 8'h3D;  // '='
    localparam logic [7:0] CHAR_CR    = 8'h0D;  // ends every result line

    // upper nibble of '0'..'9'
    localparam logic [3:0] DIGIT_ZONE = 4'h3;

    //----------------------------------------------------------------------
    // types
    //----------------------------------------------------------------------
    // digit view of an ASCII byte
    typedef struct packed {
        logic [3:0] zone;   // 0x3 for a digit
        logic [3:0] value;  // 0..9 when zone matches
    } digit_view_t;

    // received byte, raw or split into zone and value
    typedef union packed {
        logic [7:0]  raw;
        digit_view_t dig;
    } rx_char_u;

    // one parsed expression, a op b
    typedef struct packed {
        logic       op_minus;   // 1: a - b, 0: a + b
        logic [3:0] operand_a;  // first digit
        logic [3:0] operand_b;  // second digit
    } calc_expr_t;

endpackage

//--- design/cmd_parser.sv
// cmd_parser
// watches received characters for digit, digit, operator
// pulses o_expr_valid when '+' or '-' completes the pattern
// ESC or a stray character throws away partial input

module cmd_parser import calc_pkg::*; (
    input  logic       i_rst,
    input  logic       CLKOP,
    input  rx_char_u   i_rx_char,
    input  logic       i_rx_valid,
    output calc_expr_t o_expr,
    output logic       o_expr_valid
);

    //----------------------------------------------------------------------
    // character classes
    //----------------------------------------------------------------------
    logic       is_digit;
    logic       is_plus;
    logic       is_minus;
    logic       is_esc;

    logic [1:0] count_q;  // digits taken so far
    calc_expr_t expr_q;   // operands and operator being built

    // digit = zone 0x3 and value 0..9
    assign is_digit = (i_rx_char.dig.zone == DIGIT_ZONE) && (i_rx_char.dig.value <= 4'd9);
    assign is_plus  = (i_rx_char.raw == CHAR_PLUS);
    assign is_minus = (i_rx_char.raw == CHAR_MINUS);
    assign is_esc   = (i_rx_char.raw == CHAR_ESC);

    //----------------------------------------------------------------------
    // progress count and result strobe
    //----------------------------------------------------------------------
    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            count_q      <= 2'd0;
            o_expr_valid <= 1'b0;
        end else begin
            o_expr_valid <= 1'b0;
            if (i_rx_valid) begin
                if (is_esc) begin
                    count_q <= 2'd0;  // abort whatever was typed
                end else if (count_q == 2'd2) begin
                    o_expr_valid <= is_plus | is_minus;  // else expression lost
                    count_q      <= 2'd0;
                end else if (is_digit) begin
                    count_q <= count_q + 2'd1;
                end else begin
                    count_q <= 2'd0;  // non-digit, start over
                end
            end
        end
    end

    // operand store, read through digit view
    always_ff @(posedge CLKOP) begin
        if (i_rx_valid && is_digit) begin
            if (count_q == 2'd0) begin
                expr_q.operand_a <= i_rx_char.dig.value;
            end else if (count_q == 2'd1) begin
                expr_q.operand_b <= i_rx_char.dig.value;
            end
        end
        // operator slot, only used when valid fires
        if (i_rx_valid && count_q == 2'd2) expr_q.op_minus <= is_minus;
    end

    assign o_expr = expr_q;

endmodule

//--- design/result_fmt.sv
// result_fmt
// adds or subtracts the two digits of an expression
// sends "=[-][d]d<CR>" one byte at a time over valid/ready
// new expressions are ignored while a result is going out

module result_fmt import calc_pkg::*; (
    input  logic       i_rst,
    input  logic       CLKOP,
    input  calc_expr_t i_expr,
    input  logic       i_expr_valid,
    output logic [7:0] o_res_byte,
    output logic       o_res_valid,
    input  logic       i_res_ready
);

    typedef enum logic [2:0] {F_IDLE, F_EQ, F_SIGN, F_TENS, F_ONES, F_CR} fmt_state_t;

    fmt_state_t state_q;
    calc_expr_t expr_q;  // captured when idle

    logic [4:0] sum;       // 0..18
    logic [4:0] diff_mag;  // 0..9
    logic [4:0] mag;
    logic       neg;
    logic       tens;      // magnitude has two digits
    logic [3:0] ones;
    logic       take;      // byte accepted this cycle

    //----------------------------------------------------------------------
    // arithmetic on the captured digits
    //----------------------------------------------------------------------
    assign neg      = expr_q.op_minus & (expr_q.operand_b > expr_q.operand_a);
    assign sum      = {1'b0, expr_q.operand_a} + {1'b0, expr_q.operand_b};
    assign diff_mag = neg ? {1'b0, expr_q.operand_b} - {1'b0, expr_q.operand_a}
                          : {1'b0, expr_q.operand_a} - {1'b0, expr_q.operand_b};
    assign mag      = expr_q.op_minus ? diff_mag : sum;
    assign tens     = (mag >= 5'd10);
    assign ones     = tens ? 4'(mag - 5'd10) : mag[3:0];

    assign o_res_valid = (state_q != F_IDLE);
    assign take        = o_res_valid & i_res_ready;

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            state_q <= F_IDLE;
        end else begin
            case (state_q)
                F_IDLE: if (i_expr_valid) state_q <= F_EQ;
                F_EQ: begin
                    if (take) state_q <= neg ? F_SIGN : (tens ? F_TENS : F_ONES);
                end
                F_SIGN: if (take) state_q <= tens ? F_TENS : F_ONES;
                F_TENS: if (take) state_q <= F_ONES;
                F_ONES: if (take) state_q <= F_CR;
                default: if (take) state_q <= F_IDLE;  // CR sent
            endcase
        end
    end

    // expression register, frozen while busy
    always_ff @(posedge CLKOP) begin
        if (state_q == F_IDLE && i_expr_valid) expr_q <= i_expr;
    end

    // byte for the current state
    always_comb begin
        case (state_q)
            F_EQ:    o_res_byte = CHAR_EQUAL;
            F_SIGN:  o_res_byte = CHAR_MINUS;
            F_TENS:  o_res_byte = {DIGIT_ZONE, 4'd1};  // tens digit is at most 1
            F_ONES:  o_res_byte = {DIGIT_ZONE, ones};
            default: o_res_byte = CHAR_CR;
        endcase
    end

endmodule

//--- design/tx_arbiter.sv
// tx_arbiter
// merges echo bytes and result bytes onto one transmitter
// one-deep echo buffer, echo has priority

module tx_arbiter import calc_pkg::*; (
    input  logic       i_rst,
    input  logic       CLKOP,
    input  rx_char_u   i_rx_char,
    input  logic       i_rx_valid,
    input  logic [7:0] i_res_byte,
    input  logic       i_res_valid,
    output logic       o_res_ready,
    output logic [7:0] o_tx_byte,
    output logic       o_tx_valid,
    input  logic       i_tx_ready
);

    rx_char_u echo_q;       // byte waiting to be echoed
    logic     echo_full_q;
    logic     echo_take;    // transmitter took the echo

    assign echo_take = echo_full_q & i_tx_ready;

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            echo_full_q <= 1'b0;
        end else if (i_rx_valid && (!echo_full_q || echo_take)) begin
            echo_full_q <= 1'b1;  // refill, possibly same cycle as drain
        end else if (echo_take) begin
            echo_full_q <= 1'b0;
        end
        // full and not draining: new echo dropped
    end

    always_ff @(posedge CLKOP) begin
        if (i_rx_valid && (!echo_full_q || echo_take)) echo_q <= i_rx_char;
    end

    // echo first, result only when no echo waits
    assign o_tx_valid  = echo_full_q | i_res_valid;
    assign o_tx_byte   = echo_full_q ? echo_q.raw : i_res_byte;
    assign o_res_ready = ~echo_full_q & i_tx_ready;

endmodule

//--- design/uart_calc_top.sv
// uart_calc_top
// serial calculator: echo every character, answer "d d op" with the result
// rx -> parser -> formatter -> arbiter -> tx, plus rx -> arbiter for echo

module uart_calc_top import calc_pkg::*; (
    input  logic i_rst,
    input  logic CLKOP,
    input  logic i_rx,
    output logic o_tx
);

    rx_char_u   rx_char;
    logic       rx_valid;
    calc_expr_t expr;
    logic       expr_valid;
    logic [7:0] res_byte;
    logic       res_valid;
    logic       res_ready;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_ready;

    //----------------------------------------------------------------------
    // receive side
    //----------------------------------------------------------------------
    uart_rx u_rx (
        .i_rst(i_rst), .CLKOP(CLKOP), .i_rx(i_rx),
        .o_rx_char(rx_char), .o_rx_valid(rx_valid)
    );

    cmd_parser u_parser (
        .i_rst(i_rst), .CLKOP(CLKOP), .i_rx_char(rx_char), .i_rx_valid(rx_valid),
        .o_expr(expr), .o_expr_valid(expr_valid)
    );

    result_fmt u_fmt (
        .i_rst(i_rst), .CLKOP(CLKOP), .i_expr(expr), .i_expr_valid(expr_valid),
        .o_res_byte(res_byte), .o_res_valid(res_valid), .i_res_ready(res_ready)
    );

    //----------------------------------------------------------------------
    // transmit side
    //----------------------------------------------------------------------
    tx_arbiter u_arb (
        .i_rst(i_rst), .CLKOP(CLKOP), .i_rx_char(rx_char), .i_rx_valid(rx_valid),
        .i_res_byte(res_byte), .i_res_valid(res_valid), .o_res_ready(res_ready),
        .o_tx_byte(tx_byte), .o_tx_valid(tx_valid), .i_tx_ready(tx_ready)
    );

    uart_tx u_tx (
        .i_rst(i_rst), .CLKOP(CLKOP), .i_tx_byte(tx_byte), .i_tx_valid(tx_valid),
        .o_tx_ready(tx_ready), .o_tx(o_tx)
    );

endmodule

//--- sim/tb_uart_calc.sv
// tb_uart_calc
// table-driven testbench for the serial calculator
// sends characters on i_rx and decodes the reply from o_tx
// every entry expects its own echo, then the result line if one applies

module tb_uart_calc import calc_pkg::*; ();

    localparam int WAIT_CYC  = 30 * CLKS_PER_BIT;  // longest gap before a byte starts
    localparam int QUIET_CYC = 20 * CLKS_PER_BIT;  // idle window after an entry

    logic CLKOP;
    logic i_rst;
    logic i_rx;
    logic o_tx;

    string in_tab[$];   // characters to send
    string exp_tab[$];  // full text expected back

    int n_check;     // bytes compared
    int n_mismatch;
    int n_timeout;
    int n_frame;     // bad start or stop bit
    int n_extra;     // output after the expected text

    uart_calc_top i_uart_calc_top (.i_rst(i_rst), .CLKOP(CLKOP), .i_rx(i_rx), .o_tx(o_tx));

    initial begin
        CLKOP = 1'b0;
        forever #50 CLKOP = ~CLKOP;
    end

    //----------------------------------------------------------------------
    // table building
    //----------------------------------------------------------------------
    // echo of all inputs, then "=...<CR>" when a result is due
    task automatic add_entry(input string in_s, input string res_s);
        in_tab.push_back(in_s);
        if (res_s.len() > 0) exp_tab.push_back({in_s, res_s, "\015"});
        else exp_tab.push_back(in_s);
    endtask

    // "=" then sign and decimal magnitude, CR added by add_entry
    function automatic string format_result(input int a, input int b, input bit minus);
        int value;
        value = minus ? a - b : a + b;
        if (value < 0) return $sformatf("=-%0d", -value);
        return $sformatf("=%0d", value);
    endfunction

    //----------------------------------------------------------------------
    // serial driver and monitor
    //----------------------------------------------------------------------
    task automatic send_text(input string s);
        logic [9:0] frame;
        for (int c = 0; c < s.len(); c++) begin
            frame = {1'b1, s[c], 1'b0};  // stop, data, start
            for (int i = 0; i < 10; i++) begin
                @(posedge CLKOP);
                i_rx <= frame[i];
                repeat (CLKS_PER_BIT - 1) @(posedge CLKOP);
            end
        end
    endtask

    // one byte from o_tx, sampled on falling edges at mid-bit
    task automatic recv_byte(output logic [7:0] b, output bit got);
        int wait_cnt;
        wait_cnt = 0;
        b        = 8'h00;
        got      = 1'b0;
        do begin
            @(negedge CLKOP);
            wait_cnt++;
        end while (o_tx !== 1'b0 && wait_cnt < WAIT_CYC);
        if (o_tx !== 1'b0) return;  // nothing started
        repeat (CLKS_PER_BIT / 2) @(negedge CLKOP);  // middle of start bit
        if (o_tx !== 1'b0) begin
            $display("start bit on o_tx ended before mid-bit at time %0t", $time);
            n_frame++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge CLKOP);
            b[i] = o_tx;  // LSB first
        end
        repeat (CLKS_PER_BIT) @(negedge CLKOP);
        if (o_tx !== 1'b1) begin
            $display("stop bit on o_tx was low at time %0t", $time);
            n_frame++;
        end
        got = 1'b1;
    endtask

    task automatic check_output(input int ent, input string exp_s);
        logic [7:0] got_byte;
        bit         got;
        for (int k = 0; k < exp_s.len(); k++) begin
            recv_byte(got_byte, got);
            if (!got) begin
                $display("entry %0d: no output arrived on o_tx for byte %0d of %0d",
                         ent, k, exp_s.len());
                n_timeout++;
                break;  // rest of the entry would time out too
            end
            n_check++;
            if (got_byte !== exp_s[k]) begin
                $display(
                    "mismatch at time %0t: o_tx entry %0d byte %0d expected 0x%02h actual 0x%02h",
                    $time, ent, k, exp_s[k], got_byte);
                n_mismatch++;
            end
        end
    endtask

    // line must stay idle once the expected text is out
    task automatic check_quiet(input int ent);
        for (int i = 0; i < QUIET_CYC; i++) begin
            @(negedge CLKOP);
            if (o_tx !== 1'b1) begin
                $display("entry %0d: unexpected output on o_tx after the expected text", ent);
                n_extra++;
                break;
            end
        end
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        int a;
        int b;
        bit minus;
        int n_err;
        i_rst      <= 1'b1;
        i_rx       <= 1'b1;  // idle line
        n_check    = 0;
        n_mismatch = 0;
        n_timeout  = 0;
        n_frame    = 0;
        n_extra    = 0;
        void'($urandom(39));

        add_entry("a", "");        // echo only
        add_entry("47+", "=11");
        add_entry("23+", "=5");    // no tens digit
        add_entry("38-", "=-5");
        add_entry("90-", "=9");
        add_entry("1\033", "");    // ESC drops the 1
        add_entry("23+", "=5");
        add_entry("12x", "");      // x is no operator
        for (int r = 0; r < 10; r++) begin
            a     = $urandom % 10;
            b     = $urandom % 10;
            minus = 1'($urandom % 2);
            add_entry($sformatf("%0d%0d%s", a, b, minus ? "-" : "+"),
                      format_result(a, b, minus));
        end

        repeat (4) @(posedge CLKOP);
        i_rst <= 1'b0;
        repeat (4) @(posedge CLKOP);

        for (int e = 0; e < in_tab.size(); e++) begin
            fork  // reply overlaps the input
                send_text(in_tab[e]);
                check_output(e, exp_tab[e]);
            join
            check_quiet(e);
        end

        n_err = n_mismatch + n_timeout + n_frame + n_extra;
        $display("checks %0d, mismatches %0d, timeouts %0d, framing %0d, extra output %0d",
                 n_check, n_mismatch, n_timeout, n_frame, n_extra);
        if (n_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim/uart_calc_chk.sv
// uart_calc_chk
// protocol assertions for the serial calculator
// idle transmit line, digit range, result handshake stability

module uart_calc_chk import calc_pkg::*; (
    input logic       i_rst,
    input logic       CLKOP,
    input logic       i_tx_ready,
    input logic       i_tx,
    input calc_expr_t i_expr,
    input logic       i_expr_valid,
    input logic [7:0] i_res_byte,
    input logic       i_res_valid,
    input logic       i_res_ready
);

    // line idles high when the transmitter can take a byte
    a_idle_high: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_tx_ready |-> i_tx)
        else $error("o_tx low while the transmitter is ready");

    // parser only passes decimal digits
    a_digit_range: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_expr_valid |-> (i_expr.operand_a <= 4'd9 && i_expr.operand_b <= 4'd9))
        else $error("expression operand above 9");

    // held byte stays put until taken
    a_res_stable: assert property (@(posedge CLKOP) disable iff (i_rst)
        (i_res_valid && !i_res_ready) |=> (i_res_valid && $stable(i_res_byte)))
        else $error("result byte changed while waiting for ready");

endmodule

bind uart_calc_top uart_calc_chk u_chk (
    .i_rst(i_rst), .CLKOP(CLKOP), .i_tx_ready(tx_ready), .i_tx(o_tx),
    .i_expr(expr), .i_expr_valid(expr_valid),
    .i_res_byte(res_byte), .i_res_valid(res_valid), .i_res_ready(res_ready)
);

//--- uart/uart_rx.sv
// uart_rx
// 8N1 serial receiver, oversampled by CLKS_PER_BIT on CLKOP
// two-flop sync, start edge detect, mid-bit sampling
// one-cycle o_rx_valid per byte with a good stop bit

module uart_rx import calc_pkg::*; (
    input  logic     i_rst,
    input  logic     CLKOP,
    input  logic     i_rx,
    output rx_char_u o_rx_char,
    output logic     o_rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t            state_q;
    logic [1:0]           sync_q;     // metastability guard
    logic                 rx_prev_q;  // last synced level
    logic [BIT_CNT_W-1:0] cnt_q;      // cycles within a bit
    logic [2:0]           bit_idx_q;  // data bit number
    rx_char_u             shift_q;    // LSB arrives first

    logic rx_s;
    logic start_edge;
    logic half_bit;
    logic full_bit;

    assign rx_s       = sync_q[1];
    assign start_edge = rx_prev_q & ~rx_s;                           // high to low
    assign half_bit   = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT/2 - 1));  // middle of start bit
    assign full_bit   = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));    // next mid-bit

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            state_q    <= RX_IDLE;
            sync_q     <= 2'b11;  // line idles high
            rx_prev_q  <= 1'b1;
            cnt_q      <= '0;
            bit_idx_q  <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], i_rx};
            rx_prev_q  <= rx_s;
            o_rx_valid <= 1'b0;  // pulse only
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (start_edge) state_q <= RX_START;
                end
                RX_START: begin
                    if (half_bit) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_s ? RX_IDLE : RX_DATA;  // high again = glitch
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) state_q <= RX_STOP;
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
                default: begin  // RX_STOP
                    if (full_bit) begin
                        o_rx_valid <= rx_s;  // low stop bit drops the byte
                        state_q    <= RX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + BIT_CNT_W'(1);
                    end
                end
            endcase
        end
    end

    // data shifter, holds the byte until the next frame
    always_ff @(posedge CLKOP) begin
        if (state_q == RX_DATA && full_bit) shift_q.raw <= {rx_s, shift_q.raw[7:1]};
    end

    assign o_rx_char = shift_q;

endmodule

//--- uart/uart_tx.sv
// uart_tx
// 8N1 serial transmitter with valid/ready input
// start bit begins the cycle after accept, ready returns after stop bit

module uart_tx import calc_pkg::*; (
    input  logic       i_rst,
    input  logic       CLKOP,
    input  logic [7:0] i_tx_byte,
    input  logic       i_tx_valid,
    output logic       o_tx_ready,
    output logic       o_tx
);

    logic                 busy_q;
    logic                 tx_q;       // registered line
    logic [8:0]           shift_q;    // remaining data bits, stop bit on top
    logic [BIT_CNT_W-1:0] cnt_q;
    logic [3:0]           bit_idx_q;  // 0 start, 1..8 data, 9 stop

    logic accept;
    logic bit_end;
    logic last_bit;

    assign accept   = i_tx_valid & ~busy_q;
    assign bit_end  = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_idx_q == 4'd9);  // stop bit on the line

    always_ff @(posedge CLKOP or posedge i_rst) begin
        if (i_rst) begin
            busy_q    <= 1'b0;
            tx_q      <= 1'b1;  // idle high
            cnt_q     <= '0;
            bit_idx_q <= '0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            tx_q      <= 1'b0;  // start bit
            cnt_q     <= '0;
            bit_idx_q <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                cnt_q <= '0;
                if (last_bit) begin
                    busy_q <= 1'b0;  // line already high from stop bit
                end else begin
                    tx_q      <= shift_q[0];
                    bit_idx_q <= bit_idx_q + 4'd1;
                end
            end else begin
                cnt_q <= cnt_q + BIT_CNT_W'(1);
            end
        end
    end

    // payload shifter, LSB first, ones fill behind the stop bit
    always_ff @(posedge CLKOP) begin
        if (accept) begin
            shift_q <= {1'b1, i_tx_byte};
        end else if (busy_q && bit_end && !last_bit) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign o_tx_ready = ~busy_q;
    assign o_tx       = tx_q;

endmodule

//--- verilog.f
common/calc_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/cmd_parser.sv
design/result_fmt.sv
design/tx_arbiter.sv
design/uart_calc_top.sv
sim/uart_calc_chk.sv
sim/tb_uart_calc.sv
